// ==== rtl/tlb_pkg.sv ====
package tlb_pkg;

    // sv32 virtual address and pte word
    localparam int WORD_W        = 32;
    localparam int PAGE_OFFSET_W = 12;              // 4 KiB pages
    localparam int VPN_W         = WORD_W - PAGE_OFFSET_W;

    // physical page number sits above the flag and rsw bits
    localparam int PPN_W   = 22;
    localparam int PPN_LSB = 10;

    // satp asid field
    localparam int ASID_W = 9;

    // pte flag positions
    localparam int PTE_V = 0;                       // valid
    localparam int PTE_R = 1;                       // readable
    localparam int PTE_W = 2;                       // writable
    localparam int PTE_X = 3;                       // executable
    localparam int PTE_U = 4;                       // user page
    localparam int PTE_G = 5;                       // global page kept on an asid fence
    localparam int PTE_A = 6;                       // accessed
    localparam int PTE_D = 7;                       // dirty

    // index and tag widths come from each module's N_SETS
    // the tag is the upper part of the vpn, the index the lower part
    // vpn = {tag, idx}

    // rsw bits 9:8 are carried in the stored pte but never decoded
    // permission checks here look at V, R, W, A and D only

endpackage

// ==== rtl/tlb_array.sv ====
`timescale 1ns/100ps

module tlb_array #(
    parameter int N_SETS = 16
) (
    input  logic                              CLK,
    input  logic                              nRST,
    // lookup read port
    input  logic [$clog2(N_SETS)-1:0]         look_idx,
    output logic                              look_valid,
    output logic [tlb_pkg::ASID_W-1:0]        look_asid,
    output logic [tlb_pkg::VPN_W-$clog2(N_SETS)-1:0] look_tag,
    output logic [tlb_pkg::WORD_W-1:0]        look_pte,
    // fence sweep read port
    input  logic [$clog2(N_SETS)-1:0]         sweep_idx,
    output logic                              sweep_valid,
    output logic [tlb_pkg::ASID_W-1:0]        sweep_asid,
    output logic [tlb_pkg::VPN_W-$clog2(N_SETS)-1:0] sweep_tag,
    output logic [tlb_pkg::WORD_W-1:0]        sweep_pte,
    // single write port for refill or invalidate
    input  logic                              wr_en,
    input  logic [$clog2(N_SETS)-1:0]         wr_idx,
    input  logic                              wr_valid,
    input  logic [tlb_pkg::ASID_W-1:0]        wr_asid,
    input  logic [tlb_pkg::VPN_W-$clog2(N_SETS)-1:0] wr_tag,
    input  logic [tlb_pkg::WORD_W-1:0]        wr_pte
);

    localparam int IDX_W = $clog2(N_SETS);
    localparam int TAG_W = tlb_pkg::VPN_W - IDX_W;

    logic [N_SETS-1:0]               valid_q;   // one valid bit per entry
    logic [tlb_pkg::ASID_W-1:0]      asid_q [N_SETS];
    logic [TAG_W-1:0]                tag_q  [N_SETS];
    logic [tlb_pkg::WORD_W-1:0]      pte_q  [N_SETS];

    // valid bits set by refill and cleared by invalidate
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= wr_valid;
        end
    end

    // entry payload
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            asid_q[wr_idx] <= wr_asid;
            tag_q[wr_idx]  <= wr_tag;
            pte_q[wr_idx]  <= wr_pte;
        end
    end

    // combinational reads
    assign look_valid  = valid_q[look_idx];
    assign look_asid   = asid_q[look_idx];
    assign look_tag    = tag_q[look_idx];
    assign look_pte    = pte_q[look_idx];

    assign sweep_valid = valid_q[sweep_idx];
    assign sweep_asid  = asid_q[sweep_idx];
    assign sweep_tag   = tag_q[sweep_idx];
    assign sweep_pte   = pte_q[sweep_idx];

endmodule

// ==== rtl/tlb_lookup.sv ====
`timescale 1ns/100ps

module tlb_lookup #(
    parameter int N_SETS = 16
) (
    // current request
    input  logic [tlb_pkg::WORD_W-1:0]               addr,
    input  logic                                     wen,    // 1 = store
    input  logic [tlb_pkg::ASID_W-1:0]               asid,
    // entry read at the request index
    input  logic                                     look_valid,
    input  logic [tlb_pkg::ASID_W-1:0]               look_asid,
    input  logic [tlb_pkg::VPN_W-$clog2(N_SETS)-1:0] look_tag,
    input  logic [tlb_pkg::WORD_W-1:0]               look_pte,
    // results
    output logic [$clog2(N_SETS)-1:0]                look_idx,
    output logic                                     hit,
    output logic [tlb_pkg::PPN_W-1:0]                ppn,
    output logic                                     fault_load,
    output logic                                     fault_store
);

    localparam int IDX_W = $clog2(N_SETS);
    localparam int TAG_W = tlb_pkg::VPN_W - IDX_W;

    logic [TAG_W-1:0] req_tag;
    logic             load_ok;
    logic             store_ok;

    // va = {tag, idx, offset}
    assign look_idx = addr[tlb_pkg::PAGE_OFFSET_W +: IDX_W];
    assign req_tag  = addr[tlb_pkg::WORD_W-1 -: TAG_W];

    // G bit plays no part in a hit so asid must always match
    assign hit = look_valid && (look_tag == req_tag) && (look_asid == asid);

    assign ppn = look_pte[tlb_pkg::PPN_LSB +: tlb_pkg::PPN_W];

    // leaf permission check without privilege checks
    assign load_ok  = look_pte[tlb_pkg::PTE_V] & look_pte[tlb_pkg::PTE_R]
                    & look_pte[tlb_pkg::PTE_A];
    assign store_ok = look_pte[tlb_pkg::PTE_V] & look_pte[tlb_pkg::PTE_W]
                    & look_pte[tlb_pkg::PTE_A] & look_pte[tlb_pkg::PTE_D];

    assign fault_load  = ~wen & ~load_ok;   // only meaningful on completion
    assign fault_store = wen & ~store_ok;

endmodule

// ==== rtl/tlb_fence.sv ====
`timescale 1ns/100ps

module tlb_fence #(
    parameter int N_SETS = 16
) (
    input  logic                                     CLK,
    input  logic                                     nRST,
    input  logic                                     start,      // fence taken this cycle
    input  logic [tlb_pkg::WORD_W-1:0]               fence_va,   // 0 = all pages
    input  logic [tlb_pkg::ASID_W-1:0]               fence_asid, // 0 = all asids
    // entry at the sweep index
    input  logic                                     sweep_valid,
    input  logic [tlb_pkg::ASID_W-1:0]               sweep_asid,
    input  logic [tlb_pkg::VPN_W-$clog2(N_SETS)-1:0] sweep_tag,
    input  logic [tlb_pkg::WORD_W-1:0]               sweep_pte,
    output logic [$clog2(N_SETS)-1:0]                sweep_idx,
    output logic                                     inval,
    output logic                                     fence_done
);

    localparam int                  IDX_W = $clog2(N_SETS);
    localparam logic [IDX_W-1:0]    LAST  = IDX_W'(N_SETS - 1);

    logic             active;
    logic [IDX_W-1:0] cnt;
    logic             va_match;
    logic             asid_match;

    // one entry per cycle starting at 0 on the edge after start
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (start) begin
            active <= 1'b1;
            cnt    <= '0;
        end else if (active) begin
            cnt <= cnt + 1'b1;                  // wraps back to 0 after LAST
            if (cnt == LAST)
                active <= 1'b0;
        end
    end

    assign sweep_idx  = cnt;
    assign fence_done = active && (cnt == LAST);

    // entry vpn rebuilt from stored tag and its own index
    assign va_match   = ~|fence_va ||
                        ({sweep_tag, cnt} == fence_va[tlb_pkg::WORD_W-1:tlb_pkg::PAGE_OFFSET_W]);
    // global pages are kept on an asid fence
    assign asid_match = ~|fence_asid ||
                        ((sweep_asid == fence_asid) && !sweep_pte[tlb_pkg::PTE_G]);

    assign inval = active && sweep_valid && va_match && asid_match;

endmodule

// ==== rtl/tlb_ctrl.sv ====
`timescale 1ns/100ps

module tlb_ctrl #(
    parameter int N_SETS = 16
) (
    input  logic                                     CLK,
    input  logic                                     nRST,
    // requester side
    input  logic                                     req,
    input  logic [tlb_pkg::WORD_W-1:0]               addr,
    input  logic [tlb_pkg::ASID_W-1:0]               asid,
    input  logic                                     hit,
    output logic                                     busy,
    output logic                                     tlb_miss,
    // fence
    input  logic                                     fence,
    input  logic                                     fence_done,
    input  logic                                     inval,
    input  logic [$clog2(N_SETS)-1:0]                sweep_idx,
    output logic                                     start,
    // page walker
    input  logic                                     walk_busy,
    input  logic [tlb_pkg::WORD_W-1:0]               walk_pte,
    output logic                                     walk_req,
    output logic [tlb_pkg::WORD_W-1:0]               walk_addr,
    // array write port
    output logic                                     wr_en,
    output logic [$clog2(N_SETS)-1:0]                wr_idx,
    output logic                                     wr_valid,
    output logic [tlb_pkg::ASID_W-1:0]               wr_asid,
    output logic [tlb_pkg::VPN_W-$clog2(N_SETS)-1:0] wr_tag,
    output logic [tlb_pkg::WORD_W-1:0]               wr_pte
);

    localparam int IDX_W = $clog2(N_SETS);
    localparam int TAG_W = tlb_pkg::VPN_W - IDX_W;

    // fsm encoding
    localparam logic [1:0] S_LOOKUP = 2'd0;
    localparam logic [1:0] S_FETCH  = 2'd1;
    localparam logic [1:0] S_FENCE  = 2'd2;

    logic [1:0]                 state, next_state;
    logic [tlb_pkg::WORD_W-1:0] miss_addr;     // va that missed
    logic                       miss;

    assign miss = req & ~hit;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= S_LOOKUP;
        end else begin
            state <= next_state;
        end
    end

    // va captured on every lookup miss
    always_ff @(posedge CLK) begin
        if (state == S_LOOKUP && miss)
            miss_addr <= addr;
    end

    always_comb begin
        next_state = state;
        start      = 1'b0;
        busy       = 1'b1;                      // only lookup can answer
        tlb_miss   = 1'b0;
        walk_req   = 1'b0;
        wr_en      = 1'b0;
        wr_valid   = 1'b0;
        wr_idx     = sweep_idx;
        case (state)
            S_LOOKUP: begin
                busy     = req & (~hit | fence);
                tlb_miss = miss;
                if (fence) begin                // fence beats a miss
                    start      = 1'b1;
                    next_state = S_FENCE;
                end else if (miss) begin
                    next_state = S_FETCH;
                end
            end
            S_FETCH: begin
                tlb_miss = 1'b1;
                walk_req = 1'b1;
                wr_idx   = miss_addr[tlb_pkg::PAGE_OFFSET_W +: IDX_W];
                if (!walk_busy) begin           // walker answers so refill now
                    wr_en      = 1'b1;
                    wr_valid   = 1'b1;
                    next_state = S_LOOKUP;
                end
            end
            S_FENCE: begin
                wr_en = inval;                  // clear valid at sweep index
                if (fence_done)
                    next_state = S_LOOKUP;
            end
            default: next_state = S_LOOKUP;
        endcase
    end

    // refill payload that an invalidate leaves unused
    assign wr_asid   = asid;
    assign wr_tag    = miss_addr[tlb_pkg::WORD_W-1 -: TAG_W];
    assign wr_pte    = walk_pte;
    assign walk_addr = miss_addr;

endmodule

// ==== rtl/tlb.sv ====
`timescale 1ns/100ps

module tlb #(
    parameter int N_SETS = 16                   // number of entries as a power of two
) (
    input  logic                        CLK,
    input  logic                        nRST,
    // requester
    input  logic                        req,
    input  logic                        wen,
    input  logic [tlb_pkg::WORD_W-1:0]  addr,
    input  logic [tlb_pkg::ASID_W-1:0]  asid,
    output logic                        busy,
    output logic [tlb_pkg::PPN_W-1:0]   ppn,
    output logic                        fault_load,
    output logic                        fault_store,
    output logic                        tlb_miss,
    // fence
    input  logic                        fence,
    input  logic [tlb_pkg::WORD_W-1:0]  fence_va,
    input  logic [tlb_pkg::ASID_W-1:0]  fence_asid,
    output logic                        fence_done,
    // page walker
    input  logic                        walk_busy,
    input  logic [tlb_pkg::WORD_W-1:0]  walk_pte,
    output logic                        walk_req,
    output logic [tlb_pkg::WORD_W-1:0]  walk_addr
);

    localparam int IDX_W = $clog2(N_SETS);
    localparam int TAG_W = tlb_pkg::VPN_W - IDX_W;

    // lookup port
    logic [IDX_W-1:0]               look_idx;
    logic                           look_valid;
    logic [tlb_pkg::ASID_W-1:0]     look_asid;
    logic [TAG_W-1:0]               look_tag;
    logic [tlb_pkg::WORD_W-1:0]     look_pte;
    logic                           hit;
    // sweep port
    logic [IDX_W-1:0]               sweep_idx;
    logic                           sweep_valid;
    logic [tlb_pkg::ASID_W-1:0]     sweep_asid;
    logic [TAG_W-1:0]               sweep_tag;
    logic [tlb_pkg::WORD_W-1:0]     sweep_pte;
    logic                           inval;
    logic                           start;
    // write port
    logic                           wr_en;
    logic [IDX_W-1:0]               wr_idx;
    logic                           wr_valid;
    logic [tlb_pkg::ASID_W-1:0]     wr_asid;
    logic [TAG_W-1:0]               wr_tag;
    logic [tlb_pkg::WORD_W-1:0]     wr_pte;

    tlb_array #(.N_SETS(N_SETS)) i_array (.*);

    tlb_lookup #(.N_SETS(N_SETS)) i_lookup (.*);

    tlb_fence #(.N_SETS(N_SETS)) i_fence (.*);

    tlb_ctrl #(.N_SETS(N_SETS)) i_ctrl (.*);

endmodule

// ==== dv/tlb_assert.sv ====
`timescale 1ns/100ps

module tlb_assert (
    input logic CLK,
    input logic nRST,
    input logic walk_req,
    input logic walk_busy,
    input logic tlb_miss,
    input logic fence_done
);

    // walk only while a miss is pending
    a_walk_miss: assert property (@(posedge CLK) disable iff (!nRST) walk_req |-> tlb_miss)
        else $error("walk_req high without tlb_miss");

    // fence sweep and refill never overlap
    a_fence_walk: assert property (@(posedge CLK) disable iff (!nRST) fence_done |-> !walk_req)
        else $error("fence_done high during a walk");

    a_walk_hold: assert property (@(posedge CLK) disable iff (!nRST)
        walk_req && walk_busy |=> walk_req)             // held until walker answers
        else $error("walk_req dropped before walk_busy went low");

endmodule

bind tlb tlb_assert i_tlb_assert (
    .CLK        (CLK),
    .nRST       (nRST),
    .walk_req   (walk_req),
    .walk_busy  (walk_busy),
    .tlb_miss   (tlb_miss),
    .fence_done (fence_done)
);

// ==== dv/tb_tlb.sv ====
`timescale 1ns/100ps

module tb_tlb;

    localparam int N_SETS  = 16;
    localparam int IDX_W   = $clog2(N_SETS);
    localparam int TAG_W   = tlb_pkg::VPN_W - IDX_W;
    localparam int N_PAGES = 24;
    localparam int N_OPS   = 800;
    localparam int TIMEOUT = 50;                        // cycles allowed per wait

    logic                          CLK = 1'b0;
    logic                          nRST, req, wen, fence, walk_busy;
    logic [tlb_pkg::WORD_W-1:0]    addr, fence_va, walk_pte, walk_addr;
    logic [tlb_pkg::ASID_W-1:0]    asid, fence_asid;
    logic                          busy, fault_load, fault_store, tlb_miss, fence_done, walk_req;
    logic [tlb_pkg::PPN_W-1:0]     ppn;

    // mirror of the direct-mapped entries
    logic                          m_valid [N_SETS];
    logic [tlb_pkg::VPN_W-1:0]     m_vpn   [N_SETS];
    logic [tlb_pkg::ASID_W-1:0]    m_asid  [N_SETS];
    logic [tlb_pkg::WORD_W-1:0]    m_pte   [N_SETS];

    logic [tlb_pkg::WORD_W-1:0]    walk_mem [logic [tlb_pkg::ASID_W+tlb_pkg::VPN_W-1:0]];
    logic [tlb_pkg::VPN_W-1:0]     vpn_pool [N_PAGES];  // 3 pages per used index
    logic [tlb_pkg::ASID_W-1:0]    asid_pool [3];
    int                            seed;

    tlb #(.N_SETS(N_SETS)) i_tlb (.*);

    always #20 CLK = ~CLK;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "first error, run stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else stop_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    function automatic int pick_page();
        return int'($unsigned($random(seed)) % N_PAGES);
    endfunction

    function automatic int pick_asid();
        return int'($unsigned($random(seed)) % 3);
    endfunction

    // load needs V R A and store needs V W A D
    task automatic check_response(input logic [31:0] pte, input logic st);
        logic ok;
        ok = st ? (pte[tlb_pkg::PTE_V] && pte[tlb_pkg::PTE_W] && pte[tlb_pkg::PTE_A]
                   && pte[tlb_pkg::PTE_D])
                : (pte[tlb_pkg::PTE_V] && pte[tlb_pkg::PTE_R] && pte[tlb_pkg::PTE_A]);
        check_eq("ppn", 32'(ppn), 32'(pte[tlb_pkg::PPN_LSB +: tlb_pkg::PPN_W]));
        check_eq("fault_load", 32'(fault_load), 32'(!st && !ok));
        check_eq("fault_store", 32'(fault_store), 32'(st && !ok));
    endtask

    // walker keeps one entry per asid/page pair
    function automatic logic [31:0] walker_entry(input logic [8:0] a, input logic [19:0] vpn);
        logic [31:0] pte;
        logic [31:0] coin;
        if (walk_mem.exists({a, vpn}))
            return walk_mem[{a, vpn}];
        pte  = $random(seed);
        coin = $random(seed);
        if (coin[0])
            pte[7:0] = pte[7:0] | 8'hc7;                // usable page half the time
        walk_mem[{a, vpn}] = pte;
        return pte;
    endfunction

    task automatic do_request(input logic [tlb_pkg::VPN_W-1:0] vpn, input logic st);
        int          idx;
        int          cyc;
        int          dly;
        logic        exp_hit;
        logic [31:0] va;
        logic [31:0] pte;
        idx     = int'(vpn[IDX_W-1:0]);
        va      = {vpn, tlb_pkg::PAGE_OFFSET_W'($random(seed))};
        exp_hit = m_valid[idx] && (m_vpn[idx] == vpn) && (m_asid[idx] == asid);
        @(negedge CLK);
        req  = 1'b1;
        wen  = st;
        addr = va;
        #10;
        if (exp_hit) begin                              // zero-cycle answer
            check_eq("busy", 32'(busy), 32'd0);
            check_eq("walk_req", 32'(walk_req), 32'd0);
            check_response(m_pte[idx], st);
        end else begin
            check_eq("busy", 32'(busy), 32'd1);
            check_eq("tlb_miss", 32'(tlb_miss), 32'd1);
            cyc = 0;
            do begin
                @(negedge CLK);
                cyc++;
                assert (cyc < TIMEOUT) else stop_run("timeout waiting for walk_req");
            end while (!walk_req);
            check_eq("walk_addr", walk_addr, va);
            pte = walker_entry(asid, vpn);
            dly = int'($unsigned($random(seed)) % 6);
            repeat (dly) begin
                @(negedge CLK);
                check_eq("walk_req", 32'(walk_req), 32'd1);
            end
            walk_busy = 1'b0;                           // answer in this walk cycle
            walk_pte  = pte;
            @(negedge CLK);
            walk_busy = 1'b1;
            walk_pte  = $random(seed);                  // junk outside the answer
            m_valid[idx] = 1'b1;
            m_vpn[idx]   = vpn;
            m_asid[idx]  = asid;
            m_pte[idx]   = pte;
            cyc = 0;
            #10;
            while (busy) begin
                cyc++;
                assert (cyc < TIMEOUT) else stop_run("timeout waiting for busy low after refill");
                @(negedge CLK);
                #10;
            end
            check_eq("walk_req", 32'(walk_req), 32'd0);
            check_response(pte, st);
        end
        @(negedge CLK);
        req = 1'b0;
    endtask

    task automatic do_fence(input logic use_va, input logic use_asid);
        int          cyc;
        logic        va_hit;
        logic        asid_hit;
        logic [31:0] fva;
        logic [8:0]  fasid;
        fva   = use_va ? {vpn_pool[pick_page()], tlb_pkg::PAGE_OFFSET_W'($random(seed))} : '0;
        fasid = use_asid ? asid_pool[pick_asid()] : '0;
        @(negedge CLK);
        fence      = 1'b1;
        fence_va   = fva;
        fence_asid = fasid;
        @(negedge CLK);
        fence = 1'b0;
        cyc   = 1;                                      // first sweep cycle covers entry 0
        #10;
        while (!fence_done) begin
            check_eq("busy", 32'(busy), 32'd1);
            cyc++;
            assert (cyc <= 2 * N_SETS) else stop_run("timeout waiting for fence_done");
            @(negedge CLK);
            #10;
        end
        check_eq("fence cycles", 32'(cyc), 32'(N_SETS));
        for (int i = 0; i < N_SETS; i++) begin
            va_hit   = (fva == '0) || (m_vpn[i] == fva[31:tlb_pkg::PAGE_OFFSET_W]);
            asid_hit = (fasid == '0) || ((m_asid[i] == fasid) && !m_pte[i][tlb_pkg::PTE_G]);
            if (m_valid[i] && va_hit && asid_hit)
                m_valid[i] = 1'b0;                      // global pages kept on asid fence
        end
        @(negedge CLK);
    endtask

    initial begin
        logic [31:0] r;
        seed       = 32'h5787662f;
        nRST       = 1'b0;
        req        = 1'b0;
        wen        = 1'b0;
        addr       = '0;
        fence      = 1'b0;
        fence_va   = '0;
        fence_asid = '0;
        walk_busy  = 1'b1;                              // walker idles busy
        walk_pte   = '0;
        asid_pool[0] = 9'h001;
        asid_pool[1] = 9'h0a5;
        asid_pool[2] = 9'h1f0;
        asid         = asid_pool[0];
        for (int i = 0; i < N_PAGES; i++)
            vpn_pool[i] = {TAG_W'($random(seed)), IDX_W'(i % 8)};
        for (int i = 0; i < N_SETS; i++) begin
            m_valid[i] = 1'b0;
            m_vpn[i]   = '0;
            m_asid[i]  = '0;
            m_pte[i]   = '0;
        end
        repeat (5) @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);
        check_eq("walk_req", 32'(walk_req), 32'd0);
        check_eq("tlb_miss", 32'(tlb_miss), 32'd0);
        check_eq("fence_done", 32'(fence_done), 32'd0);
        check_eq("busy", 32'(busy), 32'd0);
        for (int op = 0; op < N_OPS; op++) begin
            r = $random(seed);
            if (r[3:0] == 4'd0) begin
                do_fence(r[4], r[5]);
            end else begin
                if (r[7:6] == 2'd0)
                    asid = asid_pool[pick_asid()];      // only between requests
                do_request(vpn_pool[pick_page()], r[8]);
            end
        end
        $display("test passed");
        $finish;
    end

endmodule

// ==== all.f ====
rtl/tlb_pkg.sv
rtl/tlb_array.sv
rtl/tlb_lookup.sv
rtl/tlb_fence.sv
rtl/tlb_ctrl.sv
rtl/tlb.sv
dv/tlb_assert.sv
dv/tb_tlb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the tlb testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_tlb -Mdir obj_dir -o sim_tb_tlb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb_tlb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
fi
exit $status
